// File: common/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// static display setup, same bit order as the 7-bit config word
	typedef struct packed {
		logic display_lines; // N bit of function set
		logic font;          // F bit of function set
		logic display_on;    // D
		logic cursor_on;     // C
		logic blink;         // B
		logic inc_dec;       // I/D of entry mode
		logic shift;         // S of entry mode
	} lcd_cfg_t;

	// one bus word as the host hands it over
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_word_t;

	// microsecond count, wide enough for the power-up wait
	typedef logic [8:0] lcd_us_t;

	// all three counted from the start of the bus cycle
	typedef struct packed {
		lcd_us_t setup_us; // e rises after this
		lcd_us_t high_us;  // e width
		lcd_us_t total_us; // whole cycle incl. command execution
	} bus_timing_t;

	localparam lcd_us_t power_up_us   = 9'd500;
	localparam lcd_us_t host_setup_us = 9'd1;
	localparam lcd_us_t host_high_us  = 9'd13;
	localparam lcd_us_t host_total_us = 9'd50;
	localparam lcd_us_t init_high_us  = 9'd10;

	localparam int unsigned init_steps = 4; // function set .. entry mode

endpackage

`default_nettype wire

// File: dv/lcd_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_clk_gen #(
	parameter int period_ns    = 8,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// release lines up with a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/lcd_golden.txt
// hex, one value per column, read in order
// cfg {display_lines, font, display_on, cursor_on, blink, inc_dec, shift}
05a
// expected init words {rs, rw, data}
// function set, display control, clear, entry mode
038
00e
001
006
// number of host writes
007
// host writes, columns are
// word {rs, rw, data}   pulse lcd_enable while busy   expected latched word
080 0 080
248 0 248
269 1 269
0c0 0 0c0
3a5 1 3a5
000 0 000
1ff 0 1ff

// File: dv/lcd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_tb import lcd_pkg::*; ();

	localparam int clks_per_us      = 4;
	localparam int gold_depth       = 64;
	localparam int power_up_cycles  = 500 * clks_per_us;
	localparam int init_high_cycles = 10 * clks_per_us;
	localparam int host_high_cycles = 13 * clks_per_us;
	localparam int host_rise_cycles = clks_per_us + 1; // counted from the drive edge
	localparam int host_busy_cycles = 50 * clks_per_us;
	localparam int stray_at         = 20; // cycles into a write

	logic       clk;
	logic       rst_n;
	lcd_cfg_t   cfg;
	logic       lcd_enable;
	lcd_word_t  lcd_bus;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;
	lcd_word_t  pin_word;

	logic [9:0] gold [0:gold_depth-1];
	int         init_total_us [0:3] = '{60, 60, 210, 110};
	integer     seed     = 4;
	integer     cyc      = 0; // rising edges seen so far
	integer     n_writes = 0;
	bit         loaded   = 1'b0;
	bit         e_prev   = 1'b0;
	lcd_word_t  latched_q [$];
	integer     rise_q [$];
	integer     high_q [$];

	assign pin_word = {rs, rw, lcd_data};

	lcd_clk_gen #(
		.period_ns    (8),
		.reset_cycles (5)
	) i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	lcd_top #(
		.clks_per_us (clks_per_us)
	) i_lcd_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// pin monitor samples on the falling edge
	always @(negedge clk) begin
		if (e && !e_prev) begin
			latched_q.push_back(pin_word); // what the display latches
			rise_q.push_back(cyc);
		end
		if (!e && e_prev) begin
			high_q.push_back(cyc - rise_q[$]);
		end
		e_prev = e;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input lcd_word_t got, input lcd_word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got %h expected %h", name, {got}, {exp}));
		end
	endtask

	task automatic check_cycles(input string name, input integer got, input integer exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got %0h expected %0h", name, got, exp));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	initial begin : main
		integer    i;
		integer    k;
		integer    t;
		integer    gap;
		integer    d_cyc;
		integer    n_before;
		integer    rel_cyc;
		lcd_word_t w;
		lcd_word_t exp_latch;
		bit        pulse_busy;

		cfg        = '0;
		lcd_enable = 1'b0;
		lcd_bus    = '0;
		for (i = 0; i < gold_depth; i++) begin
			gold[i] = ~10'(i); // fill depends on the address
		end
		$readmemh("dv/lcd_golden.txt", gold);
		n_writes = int'(gold[5]);
		if (n_writes < 1 || 6 + 3 * n_writes > gold_depth) begin
			abort_run("golden file is missing or holds a bad write count");
		end
		cfg    = gold[0][6:0];
		loaded = 1'b1;

		@(negedge clk);
		check_level("busy in reset", busy, 1'b1);
		check_level("e in reset", e, 1'b0);
		check_word("pins in reset", pin_word, '0);

		wait (rst_n === 1'b1);
		@(negedge clk);
		rel_cyc = cyc;
		while (busy == 1'b1) begin
			@(negedge clk);
		end

		// power-up and the four init commands
		check_cycles("init e pulses", latched_q.size(), 4);
		if (rise_q[0] - rel_cyc < power_up_cycles) begin
			abort_run("e pulsed before the power-up wait ended");
		end
		for (i = 0; i < 4; i++) begin
			check_word("init word", latched_q[i], gold[1 + i]);
			check_cycles("init e high", high_q[i], init_high_cycles);
			if (i < 3) begin
				check_cycles("init step spacing", rise_q[i + 1] - rise_q[i],
					init_total_us[i] * clks_per_us + 1);
			end
		end
		check_cycles("busy fall after init", cyc - rise_q[3], init_total_us[3] * clks_per_us);

		for (k = 0; k < n_writes; k++) begin
			w          = gold[6 + 3 * k];
			pulse_busy = gold[7 + 3 * k][0];
			exp_latch  = gold[8 + 3 * k];
			gap        = $random(seed) & 7;
			repeat (gap) @(negedge clk);
			check_level("busy before write", busy, 1'b0);
			n_before = latched_q.size();
			d_cyc    = cyc + 1;
			@(posedge clk);
			lcd_bus    <= w;
			lcd_enable <= 1'b1;
			for (t = 1; t <= host_busy_cycles + 1; t++) begin
				@(posedge clk);
				lcd_bus    <= ~w; // must not reach the pins
				lcd_enable <= pulse_busy && (t == stray_at);
				@(negedge clk);
				if (t <= host_busy_cycles) begin
					check_level("busy", busy, 1'b1);
					check_word("rs/rw/lcd_data", pin_word, w);
				end else begin
					check_level("busy", busy, 1'b0);
					check_word("idle rs/rw/lcd_data", pin_word, '0);
				end
			end
			check_cycles("e pulses per write", latched_q.size() - n_before, 1);
			check_word("latched word", latched_q[n_before], exp_latch);
			check_cycles("e rise delay", rise_q[n_before] - d_cyc, host_rise_cycles);
			check_cycles("e high", high_q[n_before], host_high_cycles);
		end

		check_cycles("latched words", latched_q.size(), 4 + n_writes);
		$display("** PASS **");
		$finish;
	end

	// limit covers power-up and init and every host cycle with margin
	initial begin : watchdog
		integer limit;

		wait (loaded);
		limit = (500 + 440 + 50 * n_writes) * clks_per_us * 3 / 2;
		repeat (limit) @(posedge clk);
		abort_run($sformatf("run timed out after %0d cycles", limit));
	end

endmodule

`default_nettype wire

// File: files.f
common/lcd_pkg.sv
lcd/lcd_timer.sv
lcd/lcd_init_rom.sv
lcd/lcd_bus_cycle.sv
lcd/lcd_ctrl.sv
logic/lcd_top.sv
dv/lcd_clk_gen.sv
dv/lcd_tb.sv

// File: lcd/lcd_bus_cycle.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_cycle import lcd_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        us_tick,
	input  logic        cycle_start,
	input  lcd_word_t   cycle_word,
	input  bus_timing_t cycle_timing,
	output logic        e,
	output logic        rs,
	output logic        rw,
	output logic [7:0]  lcd_data,
	output logic        cycle_done
);

	logic        active;
	lcd_word_t   word_q;   // pin values, held for the whole cycle
	bus_timing_t timing_q;
	lcd_us_t     us_cnt;   // microseconds since start
	lcd_us_t     elapsed;
	lcd_us_t     fall_us;
	logic        e_q;

	assign elapsed = us_cnt + lcd_us_t'(1);
	assign fall_us = timing_q.setup_us + timing_q.high_us;

	// end of total_us, pins drop on the same edge
	assign cycle_done = active && us_tick && (elapsed == timing_q.total_us);

	assign e        = e_q;
	assign rs       = word_q.rs;
	assign rw       = word_q.rw;
	assign lcd_data = word_q.data;

	always_ff @(posedge clk) begin
		if (cycle_start) begin
			timing_q <= cycle_timing;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			word_q <= '0;
			us_cnt <= '0;
			e_q    <= 1'b0;
		end else if (cycle_start) begin
			active <= 1'b1;
			word_q <= cycle_word;
			us_cnt <= '0;
			// zero setup means e rises with the data
			e_q    <= (cycle_timing.setup_us == '0);
		end else if (active && us_tick) begin
			us_cnt <= elapsed;
			if (elapsed == timing_q.total_us) begin
				active <= 1'b0;
				word_q <= '0; // back to idle levels
				e_q    <= 1'b0;
			end else if (elapsed == fall_us) begin
				e_q <= 1'b0; // display latches here
			end else if (elapsed == timing_q.setup_us) begin
				e_q <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: lcd/lcd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl import lcd_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  lcd_cfg_t    cfg,
	input  logic        lcd_enable,
	input  lcd_word_t   lcd_bus,
	input  lcd_word_t   init_word,
	input  bus_timing_t init_timing,
	input  logic        timer_done,
	input  logic        cycle_done,
	output logic [1:0]  step,
	output logic        timer_start,
	output lcd_us_t     timer_us,
	output logic        cycle_start,
	output lcd_word_t   cycle_word,
	output bus_timing_t cycle_timing,
	output logic        busy,
	output lcd_cfg_t    init_cfg
);

	typedef enum logic [1:0] {
		power_up,
		init,
		ready,
		write
	} state_t;

	localparam logic [1:0] last_step = 2'(init_steps - 1);

	localparam bus_timing_t host_timing = '{
		setup_us: host_setup_us,
		high_us:  host_high_us,
		total_us: host_total_us
	};

	state_t   state;
	logic     issued; // wait or bus cycle of this state already kicked off
	lcd_cfg_t cfg_q;

	// power-up wait starts on the first clock out of reset
	assign timer_start = (state == power_up) && !issued;
	assign timer_us    = power_up_us;

	// host word goes straight to the driver on the accepting edge
	assign cycle_start  = ((state == init) && !issued) || ((state == ready) && lcd_enable);
	assign cycle_word   = (state == init) ? init_word : lcd_bus;
	assign cycle_timing = (state == init) ? init_timing : host_timing;

	assign busy     = (state != ready);
	assign init_cfg = cfg_q;

	// config is frozen for the whole init sequence
	always_ff @(posedge clk) begin
		if (timer_done) begin
			cfg_q <= cfg;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= power_up;
			issued <= 1'b0;
			step   <= '0;
		end else begin
			case (state)
				power_up: begin
					if (timer_start) begin
						issued <= 1'b1;
					end
					if (timer_done) begin
						state  <= init;
						issued <= 1'b0;
						step   <= '0;
					end
				end
				init: begin
					if (cycle_start) begin
						issued <= 1'b1;
					end
					if (cycle_done) begin
						issued <= 1'b0; // next step issues on the following clock
						if (step == last_step) begin
							state <= ready;
						end else begin
							step <= step + 2'd1;
						end
					end
				end
				ready: begin
					if (cycle_start) begin
						state <= write;
					end
				end
				write: begin
					if (cycle_done) begin
						state <= ready; // lcd_enable ignored until here
					end
				end
				default: state <= power_up;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: lcd/lcd_init_rom.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_init_rom import lcd_pkg::*; (
	input  logic [1:0]  step,
	input  lcd_cfg_t    cfg,
	output lcd_word_t   init_word,
	output bus_timing_t init_timing
);

	// total per step, e high time plus command execution
	localparam lcd_us_t func_set_us   = 9'd60;
	localparam lcd_us_t disp_ctrl_us  = 9'd60;
	localparam lcd_us_t disp_clear_us = 9'd210; // clear is the slow one
	localparam lcd_us_t entry_mode_us = 9'd110;

	always_comb begin
		init_word.rs          = 1'b0; // all instructions
		init_word.rw          = 1'b0;
		init_timing.setup_us  = '0;   // e goes high right away
		init_timing.high_us   = init_high_us;
		init_word.data        = 8'h00;
		init_timing.total_us  = func_set_us;

		case (step)
			2'd0: begin
				// function set, 8-bit bus
				init_word.data = {4'b0011, cfg.display_lines, cfg.font, 2'b00};
				init_timing.total_us = func_set_us;
			end
			2'd1: begin
				init_word.data = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink};
				init_timing.total_us = disp_ctrl_us;
			end
			2'd2: begin
				init_word.data = 8'b0000_0001; // display clear
				init_timing.total_us = disp_clear_us;
			end
			2'd3: begin
				init_word.data = {6'b000001, cfg.inc_dec, cfg.shift};
				init_timing.total_us = entry_mode_us;
			end
			default: begin
				init_word.data = 8'h00;
				init_timing.total_us = func_set_us;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: lcd/lcd_timer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_timer import lcd_pkg::*; #(
	parameter int unsigned clks_per_us = 100
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    timer_start,
	input  logic    cycle_start,
	input  lcd_us_t timer_us,
	output logic    us_tick,
	output logic    timer_done
);

	localparam int presc_w = (clks_per_us > 1) ? $clog2(clks_per_us) : 1;
	localparam logic [presc_w-1:0] presc_last = presc_w'(clks_per_us - 1);

	logic [presc_w-1:0] presc;
	lcd_us_t            remain;
	logic               running;

	assign us_tick    = (presc == presc_last);
	assign timer_done = running && us_tick && (remain == lcd_us_t'(1));

	// either start pulse lines the microsecond grid up with itself
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc <= '0;
		end else if (timer_start || cycle_start || us_tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			remain  <= '0;
		end else if (timer_start) begin
			running <= (timer_us != '0);
			remain  <= timer_us;
		end else if (running && us_tick) begin
			remain <= remain - lcd_us_t'(1);
			if (remain == lcd_us_t'(1)) begin
				running <= 1'b0; // one-shot
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_top import lcd_pkg::*; #(
	parameter int unsigned clks_per_us = 100
) (
	input  logic       clk,
	input  logic       rst_n,
	input  lcd_cfg_t   cfg,
	input  logic       lcd_enable,
	input  lcd_word_t  lcd_bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	logic [1:0]  step;
	lcd_cfg_t    init_cfg;
	lcd_word_t   init_word;
	bus_timing_t init_timing;
	logic        timer_start;
	lcd_us_t     timer_us;
	logic        timer_done;
	logic        us_tick;
	logic        cycle_start;
	lcd_word_t   cycle_word;
	bus_timing_t cycle_timing;
	logic        cycle_done;

	lcd_ctrl i_lcd_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.lcd_enable   (lcd_enable),
		.lcd_bus      (lcd_bus),
		.init_word    (init_word),
		.init_timing  (init_timing),
		.timer_done   (timer_done),
		.cycle_done   (cycle_done),
		.step         (step),
		.timer_start  (timer_start),
		.timer_us     (timer_us),
		.cycle_start  (cycle_start),
		.cycle_word   (cycle_word),
		.cycle_timing (cycle_timing),
		.busy         (busy),
		.init_cfg     (init_cfg)
	);

	lcd_init_rom i_lcd_init_rom (
		.step        (step),
		.cfg         (init_cfg), // latched copy
		.init_word   (init_word),
		.init_timing (init_timing)
	);

	lcd_timer #(
		.clks_per_us (clks_per_us)
	) i_lcd_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.timer_start (timer_start),
		.cycle_start (cycle_start),
		.timer_us    (timer_us),
		.us_tick     (us_tick),
		.timer_done  (timer_done)
	);

	lcd_bus_cycle i_lcd_bus_cycle (
		.clk          (clk),
		.rst_n        (rst_n),
		.us_tick      (us_tick),
		.cycle_start  (cycle_start),
		.cycle_word   (cycle_word),
		.cycle_timing (cycle_timing),
		.e            (e),
		.rs           (rs),
		.rw           (rw),
		.lcd_data     (lcd_data),
		.cycle_done   (cycle_done)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the LCD controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary -j 0 -Wno-fatal --top-module lcd_tb \
	--Mdir "$obj_dir" -o lcd_sim -f files.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$obj_dir/lcd_sim" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -qF '** FAIL **' "$log"; then
	echo "simulation reported a failure, see $log"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if ! grep -qF '** PASS **' "$log"; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
exit 0
